/* bench/tb_cache_top.sv */
`timescale 1ns/10ps

module tb_cache_top
    import cache_pkg::*;
();

    localparam logic [31:0] line_a = 32'h0001_2040; // Three tags, all at set 2
    localparam logic [31:0] line_b = 32'h0003_4040;
    localparam logic [31:0] line_c = 32'h0005_6040;
    localparam int stall_limit = 200;

    logic                  clk;
    logic                  rst;
    logic                  cpu_en;
    logic [3:0]            cpu_wen;
    logic [addr_width-1:0] cpu_addr;
    logic [31:0]           cpu_wdata;
    logic [31:0]           cpu_rdata;
    logic                  cpu_stall;
    logic                  mem_req;
    logic                  mem_we;
    logic [addr_width-1:0] mem_addr;
    logic [line_width-1:0] mem_wdata;
    logic [line_width-1:0] mem_rdata;
    logic                  mem_ack;

    logic        merged_valid;
    logic [31:0] merged_addr;
    logic [31:0] merged_data;

    cache_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .cpu_en    (cpu_en),
        .cpu_wen   (cpu_wen),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .cpu_stall (cpu_stall),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack)
    );

    tb_mem_model mem_i (
        .clk       (clk),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] memory_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] wen);
        logic [31:0] result;
        for (int i = 0; i < 4; i++) begin
            result[8*i +: 8] = wen[i] ? new_word[8*i +: 8] : old_word[8*i +: 8];
        end
        return result;
    endfunction

    // Memory pattern, except for the one word that was written
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (merged_valid && {addr[31:2], 2'b00} == merged_addr) begin
            return merged_data;
        end
        return memory_word(addr);
    endfunction

    function automatic logic [line_width-1:0] expected_line(input logic [31:0] base);
        logic [line_width-1:0] line;
        for (int w = 0; w < words_per_line; w++) begin
            line[32*w +: 32] = expected_word(base + 4*w);
        end
        return line;
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_line(input string name, input logic [line_width-1:0] got,
                                input logic [line_width-1:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%064h, expected 0x%064h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic confirm_stall(input int stalls, input logic miss_expected);
        assert ((stalls > 0) == miss_expected) else begin
            $display("Access stalled for %0d cycles where a %s was expected", stalls,
                     miss_expected ? "miss" : "hit");
            abort_run();
        end
    endtask

    // One access, held until accepted; data is sampled in the cycle after acceptance
    task automatic cpu_access(input logic [31:0] addr, input logic [3:0] wen,
                              input logic [31:0] wdata, output logic [31:0] data,
                              output int stalls);
        @(posedge clk);
        #0.5;
        cpu_en = 1'b1;
        cpu_wen = wen;
        cpu_addr = addr;
        cpu_wdata = wdata;
        #1.5;
        stalls = 0;
        while (cpu_stall && stalls < stall_limit) begin
            @(posedge clk);
            #2;
            stalls++;
        end
        assert (!cpu_stall) else begin
            $display("cpu_stall did not fall within %0d cycles", stall_limit);
            abort_run();
        end
        @(posedge clk);
        #0.5;
        cpu_en = 1'b0;
        cpu_wen = 4'h0;
        #1.5;
        data = cpu_rdata;
    endtask

    task automatic cold_read_miss();
        logic [31:0] data;
        int stalls;
        check_word("cpu_stall", {31'b0, cpu_stall}, 32'h0);
        check_word("mem_req", {31'b0, mem_req}, 32'h0);
        cpu_access(line_a + 8, 4'h0, 32'h0, data, stalls);
        confirm_stall(stalls, 1'b1);
        check_word("mem_i.read_count", mem_i.read_count, 32'h1);
        check_word("mem_i.write_count", mem_i.write_count, 32'h0);
        check_word("cpu_rdata", data, expected_word(line_a + 8));
    endtask

    task automatic same_line_hit();
        logic [31:0] data;
        int stalls;
        cpu_access(line_a + 28, 4'h0, 32'h0, data, stalls);
        confirm_stall(stalls, 1'b0);
        check_word("mem_i.read_count", mem_i.read_count, 32'h1);
        check_word("cpu_rdata", data, expected_word(line_a + 28));
    endtask

    task automatic byte_write_merge();
        logic [31:0] data;
        int stalls;
        cpu_access(line_a + 4, 4'b0101, 32'hdead_beef, data, stalls);
        confirm_stall(stalls, 1'b0);
        check_word("cpu_rdata after write", data, 32'h0);
        merged_addr = line_a + 4;
        merged_data = merge_bytes(memory_word(line_a + 4), 32'hdead_beef, 4'b0101);
        merged_valid = 1'b1;
        cpu_access(line_a + 4, 4'h0, 32'h0, data, stalls);
        confirm_stall(stalls, 1'b0);
        check_word("cpu_rdata", data, merged_data);
    endtask

    task automatic two_way_resident();
        logic [31:0] data;
        int stalls;
        cpu_access(line_b + 12, 4'h0, 32'h0, data, stalls);
        confirm_stall(stalls, 1'b1);
        check_word("cpu_rdata", data, expected_word(line_b + 12));
        // Ends on line B, so line A is the LRU way
        for (int k = 0; k < 3; k++) begin
            cpu_access(line_a + 4*k, 4'h0, 32'h0, data, stalls);
            confirm_stall(stalls, 1'b0);
            check_word("cpu_rdata", data, expected_word(line_a + 4*k));
            cpu_access(line_b + 4*k, 4'h0, 32'h0, data, stalls);
            confirm_stall(stalls, 1'b0);
            check_word("cpu_rdata", data, expected_word(line_b + 4*k));
        end
        check_word("mem_i.read_count", mem_i.read_count, 32'h2);
        check_word("mem_i.write_count", mem_i.write_count, 32'h0);
    endtask

    task automatic lru_eviction();
        logic [31:0] data;
        int stalls;
        cpu_access(line_c + 20, 4'h0, 32'h0, data, stalls);
        confirm_stall(stalls, 1'b1);
        check_word("cpu_rdata", data, expected_word(line_c + 20));
        check_word("mem_i.write_count", mem_i.write_count, 32'h1);
        check_word("mem_i.read_count", mem_i.read_count, 32'h3);
        check_word("mem_i.last_wr_addr", mem_i.last_wr_addr, line_a);
        compare_line("mem_i.last_wr_data", mem_i.last_wr_data, expected_line(line_a));
        assert (mem_i.last_wr_order < mem_i.last_rd_order) else begin
            $display("Write-back of the dirty line did not come before the refill read");
            abort_run();
        end
        cpu_access(line_a + 4, 4'h0, 32'h0, data, stalls); // Evicts clean line B
        confirm_stall(stalls, 1'b1);
        check_word("cpu_rdata", data, merged_data);
        check_word("mem_i.write_count", mem_i.write_count, 32'h1);
        check_word("mem_i.read_count", mem_i.read_count, 32'h4);
    endtask

    task automatic pipelined_hits();
        logic [31:0] addrs [16];
        for (int i = 0; i < 16; i++) begin
            addrs[i] = ((i % 2) == 0 ? line_a : line_c) + 4*(i / 2); // Alternate ways
        end
        for (int i = 0; i <= 16; i++) begin
            @(posedge clk);
            #0.5;
            cpu_en = (i < 16);
            cpu_wen = 4'h0;
            cpu_addr = (i < 16) ? addrs[i] : 32'h0;
            #1.5;
            if (i < 16) begin
                confirm_stall(cpu_stall ? 1 : 0, 1'b0);
            end
            if (i > 0) begin
                check_word("cpu_rdata", cpu_rdata, expected_word(addrs[i-1]));
            end
        end
        check_word("mem_i.read_count", mem_i.read_count, 32'h4);
    endtask

    initial begin
        rst = 1'b1;
        cpu_en = 1'b0;
        cpu_wen = 4'h0;
        cpu_addr = '0;
        cpu_wdata = '0;
        merged_valid = 1'b0;
        merged_addr = '0;
        merged_data = '0;
        repeat (8) @(posedge clk);
        #0.5;
        rst = 1'b0;
        cold_read_miss();
        same_line_hit();
        byte_write_merge();
        two_way_resident();
        lru_eviction();
        pipelined_hits();
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* bench/tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  mem_req,
    input  logic                  mem_we,
    input  logic [addr_width-1:0] mem_addr,
    input  logic [line_width-1:0] mem_wdata,
    output logic [line_width-1:0] mem_rdata,
    output logic                  mem_ack
);

    integer seed;
    int     delay;
    int     read_count;
    int     write_count;
    int     op_count;
    int     last_rd_order;
    int     last_wr_order;
    logic [addr_width-1:0] last_wr_addr;
    logic [line_width-1:0] last_wr_data;

    // Written lines; every other line keeps its initial pattern
    logic [addr_width-1:0] stored_addr [16];
    logic [line_width-1:0] stored_line [16];
    int                    stored_count;

    function automatic logic [line_width-1:0] line_content(input logic [addr_width-1:0] addr);
        logic [addr_width-1:0] base;
        logic [line_width-1:0] line;
        base = {addr[addr_width-1:offset_width], offset_width'(0)};
        for (int w = 0; w < words_per_line; w++) begin
            line[32*w +: 32] = (base + 4*w) ^ 32'h5a5a_0000; // Byte address of the word
        end
        for (int i = 0; i < stored_count; i++) begin
            if (stored_addr[i] == base) begin
                line = stored_line[i];
            end
        end
        return line;
    endfunction

    task automatic store_line(input logic [addr_width-1:0] addr,
                              input logic [line_width-1:0] data);
        int slot;
        slot = stored_count;
        for (int i = 0; i < stored_count; i++) begin
            if (stored_addr[i] == addr) begin
                slot = i;
            end
        end
        if (slot < 16) begin
            stored_addr[slot] = addr;
            stored_line[slot] = data;
            if (slot == stored_count) begin
                stored_count++;
            end
        end
    endtask

    initial begin
        seed = 32'h96ca_ca70;
        mem_ack = 1'b0;
        mem_rdata = '0;
        read_count = 0;
        write_count = 0;
        op_count = 0;
        last_rd_order = 0;
        last_wr_order = 0;
        stored_count = 0;
        forever begin
            @(posedge clk);
            #0.5;
            if (mem_req) begin
                delay = 1 + ({$random(seed)} % 6);
                repeat (delay - 1) begin
                    @(posedge clk);
                    #0.5;
                end
                op_count++;
                if (mem_we) begin
                    store_line(mem_addr, mem_wdata);
                    write_count++;
                    last_wr_addr = mem_addr;
                    last_wr_data = mem_wdata;
                    last_wr_order = op_count;
                end else begin
                    mem_rdata = line_content(mem_addr);
                    read_count++;
                    last_rd_order = op_count;
                end
                mem_ack = 1'b1;
                @(posedge clk);
                #0.5;
                mem_ack = 1'b0; // Request has dropped at this edge
            end
        end
    end

endmodule

/* rtl/cache_ctrl.sv */
`timescale 1ns/10ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_en,
    input  logic [addr_width-1:0] cpu_addr,
    input  logic [num_ways-1:0]   hit,
    input  logic                  victim_dirty,
    input  logic [tag_width-1:0]  victim_tag,
    input  cache_line_u           old_line,
    input  logic [line_width-1:0] mem_rdata,
    input  logic                  mem_ack,
    output logic                  cpu_stall,
    output logic                  write_back,
    output logic                  refresh,
    output cache_line_u           refill_line,
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [addr_width-1:0] mem_addr,
    output logic [line_width-1:0] mem_wdata
);

    ctrl_state_e state;

    logic [tag_width-1:0]   req_tag;
    logic [index_width-1:0] req_index;
    logic                   miss;

    assign req_tag = cpu_addr[addr_width-1 -: tag_width];
    assign req_index = cpu_addr[offset_width +: index_width];
    assign miss = cpu_en & ~(|hit);

    assign cpu_stall = (state != st_idle) | miss;

    // Banks read the victim at the next edge
    assign write_back = (state == st_idle) & miss & victim_dirty;
    assign refresh = state == st_refill;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            mem_req <= 1'b0;
            mem_we <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (miss) begin
                        if (victim_dirty) begin
                            state <= st_write_back;
                        end else begin
                            state <= st_fill_req;
                            mem_req <= 1'b1;
                            mem_we <= 1'b0;
                        end
                    end
                end
                st_write_back: begin
                    if (!mem_req) begin
                        mem_req <= 1'b1; // Old line is on the bank outputs now
                        mem_we <= 1'b1;
                    end else if (mem_ack) begin
                        mem_req <= 1'b0;
                        mem_we <= 1'b0;
                        state <= st_fill_req;
                    end
                end
                st_fill_req: begin
                    if (!mem_req) begin
                        mem_req <= 1'b1;
                        mem_we <= 1'b0;
                    end else if (mem_ack) begin
                        mem_req <= 1'b0;
                        state <= st_refill;
                    end
                end
                st_refill: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Address and data for the memory port, loaded as the request rises
    always_ff @(posedge clk) begin
        if (state == st_write_back && !mem_req) begin
            mem_addr <= {victim_tag, req_index, offset_width'(0)};
            mem_wdata <= old_line.flat;
        end else if (!mem_req) begin
            mem_addr <= {req_tag, req_index, offset_width'(0)};
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fill_req && mem_req && mem_ack) begin
            refill_line.flat <= mem_rdata; // Read data valid with the ack
        end
    end

endmodule

/* rtl/cache_data.sv */
`timescale 1ns/10ps

module cache_data
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_en,
    input  logic [3:0]            cpu_wen,
    input  logic [addr_width-1:0] cpu_addr,
    input  logic [31:0]           cpu_wdata,
    input  logic [num_ways-1:0]   hit,
    input  logic                  lru,
    input  logic                  write_back,
    input  logic                  refresh,
    input  cache_line_u           refill_line,
    output logic [31:0]           cpu_rdata,
    output cache_line_u           old_line
);

    logic [index_width-1:0]    index;
    logic [word_sel_width-1:0] word;
    logic [word_sel_width-1:0] word_r;
    logic [words_per_line-1:0] bank_sel;
    logic [num_ways-1:0]       fill_way;
    logic [num_ways-1:0]       rd_hit_r;
    logic [31:0]               bank_rdata [num_ways][words_per_line];
    cache_line_u               way_line [num_ways];

    assign index = cpu_addr[offset_width +: index_width];
    assign word = cpu_addr[offset_width-1 -: word_sel_width];
    assign bank_sel = words_per_line'(1) << word;

    // Refill goes only into the LRU way
    assign fill_way = {num_ways{refresh}} & (num_ways'(1) << lru);

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        for (genvar b = 0; b < words_per_line; b++) begin : g_bank
            logic        bank_en;
            logic [3:0]  bank_wen;
            logic [31:0] bank_wdata;

            // Write-back reads every bank of both ways
            assign bank_en = write_back | fill_way[w] | (cpu_en & hit[w] & bank_sel[b]);
            assign bank_wen = fill_way[w] ? 4'hf :
                              write_back  ? 4'h0 : cpu_wen;
            assign bank_wdata = refresh ? refill_line.words[b] : cpu_wdata;

            data_bank bank_i (
                .clk   (clk),
                .en    (bank_en),
                .wen   (bank_wen),
                .addr  (index),
                .wdata (bank_wdata),
                .rdata (bank_rdata[w][b])
            );
        end
    end

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            for (int b = 0; b < words_per_line; b++) begin
                way_line[w].words[b] = bank_rdata[w][b];
            end
        end
    end

    // Word and way of the previous read hit
    always_ff @(posedge clk) begin
        if (rst) begin
            word_r <= '0;
            rd_hit_r <= '0;
        end else begin
            word_r <= word;
            rd_hit_r <= hit & {num_ways{cpu_en & ~(|cpu_wen)}}; // Writes return zero
        end
    end

    always_comb begin
        cpu_rdata = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (rd_hit_r[w]) begin
                cpu_rdata = way_line[w].words[word_r];
            end
        end
    end

    assign old_line = way_line[lru]; // Victim line for write-back

endmodule

/* rtl/cache_pkg.sv */
package cache_pkg;

    localparam int addr_width = 32;
    localparam int tag_width = 20;
    localparam int index_width = 7;
    localparam int offset_width = 5;

    localparam int num_sets = 128;
    localparam int num_ways = 2;
    localparam int words_per_line = 8;
    localparam int word_sel_width = $clog2(words_per_line);
    localparam int line_width = 256;

    // One cache line, seen flat on the memory side and as words by the banks
    typedef union packed {
        logic [line_width-1:0] flat;
        logic [words_per_line-1:0][31:0] words; // Word 0 in the low bits
    } cache_line_u;

    // Miss handling states
    typedef enum logic [1:0] {
        st_idle,
        st_write_back, // Dirty victim goes out first
        st_fill_req,
        st_refill
    } ctrl_state_e;

endpackage

/* rtl/cache_tag.sv */
`timescale 1ns/10ps

module cache_tag
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_en,
    input  logic                  cpu_stall,
    input  logic [3:0]            cpu_wen,
    input  logic [addr_width-1:0] cpu_addr,
    input  logic                  refresh,
    output logic [num_ways-1:0]   hit,
    output logic                  lru,
    output logic                  victim_dirty,
    output logic [tag_width-1:0]  victim_tag
);

    logic [tag_width-1:0]               tags [num_ways][num_sets];
    logic [num_ways-1:0][num_sets-1:0]  valid;
    logic [num_ways-1:0][num_sets-1:0]  dirty;
    logic [num_sets-1:0]                lru_bits;

    logic [tag_width-1:0]   tag;
    logic [index_width-1:0] index;
    logic                   accept;
    logic                   hit_way;

    assign tag = cpu_addr[addr_width-1 -: tag_width];
    assign index = cpu_addr[offset_width +: index_width];

    // Lookup at the request index
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit[w] = valid[w][index] && (tags[w][index] == tag);
        end
    end

    assign hit_way = hit[1];
    assign accept = cpu_en & ~cpu_stall & (|hit);

    assign lru = lru_bits[index];
    assign victim_dirty = valid[lru][index] & dirty[lru][index];
    assign victim_tag = tags[lru][index];

    always_ff @(posedge clk) begin
        if (refresh) begin
            tags[lru][index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
            lru_bits <= '0;
        end else if (refresh) begin
            // New line arrives clean
            valid[lru][index] <= 1'b1;
            dirty[lru][index] <= 1'b0;
        end else if (accept) begin
            lru_bits[index] <= ~hit_way; // Other way becomes the victim
            if (|cpu_wen) begin
                dirty[hit_way][index] <= 1'b1;
            end
        end
    end

endmodule

/* rtl/cache_top.sv */
`timescale 1ns/10ps

module cache_top
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_en,
    input  logic [3:0]            cpu_wen,
    input  logic [addr_width-1:0] cpu_addr,
    input  logic [31:0]           cpu_wdata,
    output logic [31:0]           cpu_rdata,
    output logic                  cpu_stall,
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [addr_width-1:0] mem_addr,
    output logic [line_width-1:0] mem_wdata,
    input  logic [line_width-1:0] mem_rdata,
    input  logic                  mem_ack
);

    logic [num_ways-1:0]  hit;
    logic                 lru;
    logic                 victim_dirty;
    logic [tag_width-1:0] victim_tag;
    logic                 write_back;
    logic                 refresh;
    cache_line_u          refill_line;
    cache_line_u          old_line;

    cache_tag tag_i (
        .clk          (clk),
        .rst          (rst),
        .cpu_en       (cpu_en),
        .cpu_stall    (cpu_stall),
        .cpu_wen      (cpu_wen),
        .cpu_addr     (cpu_addr),
        .refresh      (refresh),
        .hit          (hit),
        .lru          (lru),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    cache_data data_i (
        .clk         (clk),
        .rst         (rst),
        .cpu_en      (cpu_en),
        .cpu_wen     (cpu_wen),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .hit         (hit),
        .lru         (lru),
        .write_back  (write_back),
        .refresh     (refresh),
        .refill_line (refill_line),
        .cpu_rdata   (cpu_rdata),
        .old_line    (old_line)
    );

    cache_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .cpu_en       (cpu_en),
        .cpu_addr     (cpu_addr),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .old_line     (old_line),
        .mem_rdata    (mem_rdata),
        .mem_ack      (mem_ack),
        .cpu_stall    (cpu_stall),
        .write_back   (write_back),
        .refresh      (refresh),
        .refill_line  (refill_line),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

endmodule

/* rtl/data_bank.sv */
`timescale 1ns/10ps

module data_bank
    import cache_pkg::*;
(
    input  logic                   clk,
    input  logic                   en,
    input  logic [3:0]             wen,
    input  logic [index_width-1:0] addr,
    input  logic [31:0]            wdata,
    output logic [31:0]            rdata
);

    logic [31:0] mem [num_sets];

    // Read-first, so a write returns the old word
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
            for (int i = 0; i < 4; i++) begin
                if (wen[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

/* tb.f */
rtl/cache_pkg.sv
rtl/data_bank.sv
rtl/cache_data.sv
rtl/cache_tag.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
bench/tb_mem_model.sv
bench/tb_cache_top.sv
